//--- list.f
fetch_pkg.sv
fetch_mem_port.sv
fetch_pc_select.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_mem.sv
tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_fetch_top.sv
// directed tests for the fetch stage, each test places a program and walks its list
// stall_id_i is only raised together with stall_if_i, as a real pipeline would
// inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int N_INSTR        = 59;
  localparam int TIMEOUT_CYCLES = 40 * N_INSTR;

  logic        clk;
  logic        rst_n;
  logic [31:0] boot_addr_i;
  logic        req_i;
  logic        stall_if_i;
  logic        stall_id_i;
  redirect_t   redirect_i;
  logic        valid_o;
  logic [31:0] pc_if_o;
  if_id_t      if_id_o;
  logic        busy_o;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic [1:0]  gnt_delay;

  // program layout of the last placed image, and the expected IF/ID stream
  logic [31:0] lay_pc[$];
  logic [31:0] lay_ins[$];
  bit          lay_16[$];
  logic [31:0] exp_pc[$];
  logic [31:0] exp_ins[$];
  bit          exp_16[$];
  // same pcs, consumed as instructions leave IF
  logic [31:0] if_exp_pc[$];

  logic [31:0] mem_rng;
  logic [31:0] stall_rng;
  logic [31:0] e_pc;
  logic [31:0] e_ins;
  bit          e_16;
  bit          id_loaded;
  bit          rd_out;
  if_id_t      if_id_prev;
  string       cur_test;
  int          n_checks;
  int          n_errors;
  int          cycles;

  fetch_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_addr_i    (boot_addr_i),
    .req_i          (req_i),
    .stall_if_i     (stall_if_i),
    .stall_id_i     (stall_id_i),
    .redirect_i     (redirect_i),
    .valid_o        (valid_o),
    .pc_if_o        (pc_if_o),
    .if_id_o        (if_id_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  tb_fetch_mem u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .delay_i  (gnt_delay),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // new grant delay every cycle, 0 to 3
  always @(posedge clk) begin
    #1;
    mem_rng   = xorshift32(mem_rng);
    gnt_delay = mem_rng[1:0];
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, instructions stopped reaching IF/ID", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check(input string what, input logic [64:0] exp, input logic [64:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // IF/ID monitor
  //////////////////////////////////////////////////////////////////////

  // IF/ID loaded at this edge when stall_id_i was low before it
  always @(posedge clk) begin
    id_loaded <= !stall_id_i;
  end

  // one read granted on the bus and not yet returned
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_out <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      rd_out <= 1'b1;
    end else if (instr_rvalid_i) begin
      rd_out <= 1'b0;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (!id_loaded) begin
        check("if_id held", if_id_prev, if_id_o);
      end else if (if_id_o.id_valid) begin
        if (exp_pc.size() == 0) begin
          n_errors++;
          $display("%s: pc %h reached IF/ID with nothing expected", cur_test, if_id_o.pc);
        end else begin
          e_pc  = exp_pc.pop_front();
          e_ins = exp_ins.pop_front();
          e_16  = exp_16.pop_front();
          check("pc", {33'h0, e_pc}, {33'h0, if_id_o.pc});
          // compressed ones only own the low halfword
          if (e_16) begin
            check("instr16", {49'h0, e_ins[15:0]}, {49'h0, if_id_o.instr[15:0]});
          end else begin
            check("instr32", {33'h0, e_ins}, {33'h0, if_id_o.instr});
          end
        end
      end
      // a request on the bus or a read still out is a fetch in flight
      if (instr_req_o || rd_out) begin
        check("busy_o", 65'h1, {64'h0, busy_o});
      end
      if_id_prev = if_id_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // program images and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic write_half(input logic [31:0] addr, input logic [15:0] h);
    if (addr[1]) begin
      u_mem.mem[addr[14:2]][31:16] = h;
    end else begin
      u_mem.mem[addr[14:2]][15:0] = h;
    end
  endtask

  // sizes is a string of 2 and 4, one character per instruction
  task automatic place_program(input logic [31:0] start, input string sizes);
    logic [31:0] pc;
    logic [31:0] ins;
    lay_pc.delete();
    lay_ins.delete();
    lay_16.delete();
    pc = start;
    for (int i = 0; i < sizes.len(); i++) begin
      if (sizes[i] == "2") begin
        ins = {16'h0, pc[13:0], 2'b01};
        write_half(pc, ins[15:0]);
        lay_16.push_back(1'b1);
      end else begin
        ins = {8'ha5, pc[21:0], 2'b11};
        write_half(pc, ins[15:0]);
        write_half(pc + 32'd2, ins[31:16]);
        lay_16.push_back(1'b0);
      end
      lay_pc.push_back(pc);
      lay_ins.push_back(ins);
      pc = pc + (sizes[i] == "2" ? 32'd2 : 32'd4);
    end
  endtask

  task automatic expect_first(input int n);
    for (int i = 0; i < n; i++) begin
      exp_pc.push_back(lay_pc[i]);
      exp_ins.push_back(lay_ins[i]);
      exp_16.push_back(lay_16[i]);
      if_exp_pc.push_back(lay_pc[i]);
    end
  endtask

  function automatic redirect_t jal_to(input logic [31:0] target);
    redirect_t r;
    r                = '0;
    r.pc_sel         = PC_JUMP;
    r.jump_in_id     = JUMP_JAL;
    r.jump_target_id = target;
    return r;
  endfunction

  function automatic redirect_t branch_to(input logic [31:0] target, input bit taken);
    redirect_t r;
    r                = '0;
    r.pc_sel         = PC_BRANCH;
    r.jump_in_ex     = JUMP_COND;
    r.branch_taken   = taken;
    r.jump_target_ex = target;
    return r;
  endfunction

  // exceptions and eret travel as JAL-like redirects
  function automatic redirect_t trap_to(input pc_sel_e sel, input exc_cause_e cause,
                                        input logic [31:0] epc);
    redirect_t r;
    r            = '0;
    r.pc_sel     = sel;
    r.jump_in_id = JUMP_JAL;
    r.exc_cause  = cause;
    r.epc        = epc;
    return r;
  endfunction

  task automatic take_redirect(input redirect_t r);
    redirect_i = r;
    @(posedge clk);
    #1;
    redirect_i = '0;
  endtask

  // outputs right after reset, before any request
  task automatic check_reset_outputs();
    @(negedge clk);
    check("valid_o", 65'h0, {64'h0, valid_o});
    check("instr_req_o", 65'h0, {64'h0, instr_req_o});
    check("busy_o", 65'h0, {64'h0, busy_o});
    check("id_valid", 65'h0, {64'h0, if_id_o.id_valid});
    @(posedge clk);
    #1;
  endtask

  // keeps req_i high until n instructions are taken, optional random stalls
  task automatic run_stream(input int n, input bit bp);
    int          taken;
    int          stall_left;
    bit          stall_both;
    logic [31:0] want_pc;
    taken      = 0;
    stall_left = 0;
    stall_both = 1'b0;
    req_i      = 1'b1;
    while (taken < n) begin
      @(negedge clk);
      if (valid_o && !stall_if_i) begin
        taken++;
        // pc in IF for the instruction leaving at the next edge
        if (if_exp_pc.size() == 0) begin
          n_errors++;
          $display("%s: IF offered pc %h with nothing expected", cur_test, pc_if_o);
        end else begin
          want_pc = if_exp_pc.pop_front();
          check("pc_if", {33'h0, want_pc}, {33'h0, pc_if_o});
        end
      end
      @(posedge clk);
      #1;
      if (bp && stall_left == 0) begin
        stall_rng = xorshift32(stall_rng);
        if (stall_rng[1:0] == 2'b00) begin
          stall_left = 1 + int'(stall_rng[4:2]);
          stall_both = stall_rng[5];
        end
      end
      if (stall_left != 0) begin
        stall_if_i = 1'b1;
        stall_id_i = stall_both;
        stall_left--;
      end else begin
        stall_if_i = 1'b0;
        stall_id_i = 1'b0;
      end
    end
  endtask

  task automatic stop_stream();
    req_i      = 1'b0;
    stall_if_i = 1'b0;
    stall_id_i = 1'b0;
  endtask

  task automatic drain();
    int i;
    i = 0;
    while (exp_pc.size() != 0 && i < 20) begin
      @(posedge clk);
      #1;
      i++;
    end
    if (exp_pc.size() != 0) begin
      n_errors++;
      $display("%s: %0d expected instructions never reached IF/ID", cur_test, exp_pc.size());
      exp_pc.delete();
      exp_ins.delete();
      exp_16.delete();
      if_exp_pc.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_boot();
    cur_test = "boot";
    place_program((boot_addr_i & 32'hffff_ffe0) + 32'h00, "444444");
    expect_first(6);
    run_stream(6, 1'b0);
    stop_stream();
    drain();
  endtask

  task automatic test_mixed();
    cur_test = "mixed";
    place_program(32'h2000, "22424244224");
    expect_first(11);
    take_redirect(jal_to(32'h2000));
    run_stream(11, 1'b0);
    stop_stream();
    drain();
  endtask

  task automatic test_jumps();
    cur_test = "jumps";
    // jump while streaming, compressed at the halfword target
    place_program(32'h3000, "42424");
    expect_first(3);
    place_program(32'h3102, "242");
    expect_first(3);
    take_redirect(jal_to(32'h3000));
    run_stream(3, 1'b0);
    take_redirect(jal_to(32'h3102));
    run_stream(3, 1'b0);
    stop_stream();
    drain();
    // crossword 32-bit at the target
    place_program(32'h3206, "424");
    expect_first(3);
    take_redirect(jal_to(32'h3206));
    run_stream(3, 1'b0);
    stop_stream();
    drain();
  endtask

  task automatic test_branches();
    cur_test = "branches";
    place_program(32'h4000, "4444");
    expect_first(2);
    place_program(32'h4102, "22442");
    expect_first(5);
    take_redirect(jal_to(32'h4000));
    run_stream(2, 1'b0);
    take_redirect(branch_to(32'h4102, 1'b1));
    run_stream(3, 1'b0);
    stop_stream();
    // not taken, the sequential order goes on
    take_redirect(branch_to(32'h4f00, 1'b0));
    run_stream(2, 1'b0);
    stop_stream();
    drain();
  endtask

  task automatic test_exceptions();
    logic [4:0]  offs [4];
    logic [31:0] vec;
    cur_test = "exceptions";
    offs[0] = 5'h00;
    offs[1] = 5'h08;
    offs[2] = 5'h10;
    offs[3] = 5'h18;
    for (int c = 0; c < 4; c++) begin
      vec = (boot_addr_i & 32'hffff_ffe0) + {27'h0, offs[c]};
      place_program(vec, "42");
      expect_first(2);
      take_redirect(trap_to(PC_EXCEPTION, exc_cause_e'(c), 32'h0));
      run_stream(2, 1'b0);
      stop_stream();
      drain();
    end
    place_program(32'h5002, "42");
    expect_first(2);
    take_redirect(trap_to(PC_ERET, EXC_RESET, 32'h5002));
    run_stream(2, 1'b0);
    stop_stream();
    drain();
  endtask

  task automatic test_backpressure();
    cur_test = "backpressure";
    place_program(32'h6000, "2424224224422442");
    expect_first(16);
    take_redirect(jal_to(32'h6000));
    run_stream(8, 1'b1);
    // redirect under stall_id_i must be ignored
    stall_if_i = 1'b1;
    stall_id_i = 1'b1;
    take_redirect(jal_to(32'h6f02));
    run_stream(8, 1'b1);
    stop_stream();
    drain();
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    boot_addr_i = 32'h0000_1234;
    req_i       = 1'b0;
    stall_if_i  = 1'b0;
    stall_id_i  = 1'b0;
    redirect_i  = '0;
    gnt_delay   = 2'd0;
    mem_rng     = 32'd11;
    stall_rng   = 32'd11;
    id_loaded   = 1'b0;
    rd_out      = 1'b0;
    if_id_prev  = '0;
    n_checks    = 0;
    n_errors    = 0;
    cycles      = 0;
    cur_test    = "reset";
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_reset_outputs();
    test_boot();
    test_mixed();
    test_jumps();
    test_branches();
    test_exceptions();
    test_backpressure();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tb_fetch_mem.sv
// behavioral instruction memory, 8k words, address bits 14:2 select the word
// grant comes after delay_i cycles of request, delay_i is sampled at each grant
// read data returns one cycle after the grant, one read at a time
`timescale 1ns/1ps

module tb_fetch_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [1:0]  delay_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [0:8191];
  logic [1:0]  cnt_q;
  logic [1:0]  delay_q;
  logic [12:0] fill_idx;

  // every word starts as a 32-bit instruction tagged with its own address
  initial begin
    for (int i = 0; i < 8192; i++) begin
      fill_idx = i[12:0];
      mem[i]   = {3'b101, fill_idx, fill_idx ^ 13'h0aaa, 3'b111};
    end
  end

  // grant depends on registered state only, not on the request itself
  assign gnt_o = (cnt_q >= delay_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= 2'd0;
      delay_q  <= 2'd0;
      rvalid_o <= 1'b0;
    end else if (req_i && gnt_o) begin
      rvalid_o <= 1'b1;
      cnt_q    <= 2'd0;
      delay_q  <= delay_i;
    end else begin
      rvalid_o <= 1'b0;
      if (req_i) begin
        cnt_q <= cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_i && gnt_o) begin
      rdata_o <= mem[addr_i[14:2]];
    end
  end

endmodule

//--- fetch_top.sv
// top level of the fetch stage, pins map one to one onto fetch_stage
// decode and execute live outside, their controls arrive on redirect_i
`timescale 1ns/1ps

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          boot_addr_i,
  // pipeline control
  input  logic                 req_i,
  input  logic                 stall_if_i,
  input  logic                 stall_id_i,
  input  fetch_pkg::redirect_t redirect_i,
  // to decode
  output logic                 valid_o,
  output logic [31:0]          pc_if_o,
  output fetch_pkg::if_id_t    if_id_o,
  output logic                 busy_o,
  // instruction memory
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i
);

  fetch_stage u_fetch_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .boot_addr_i    (boot_addr_i),
    .req_i          (req_i),
    .stall_if_i     (stall_if_i),
    .stall_id_i     (stall_id_i),
    .redirect_i     (redirect_i),
    .valid_o        (valid_o),
    .pc_if_o        (pc_if_o),
    .if_id_o        (if_id_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

endmodule

//--- fetch_stage.sv
// instruction fetch stage with realignment of 16-bit and crossword 32-bit instructions
// a redirect is taken only when stall_id_i is low, a taken branch in EX wins over ID
// the instruction sitting in IF when a redirect is taken is dropped, not passed to ID
// IF/ID loads on every edge with stall_id_i low
`timescale 1ns/1ps

module fetch_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          boot_addr_i,
  // pipeline control
  input  logic                 req_i,
  input  logic                 stall_if_i,
  input  logic                 stall_id_i,
  input  fetch_pkg::redirect_t redirect_i,
  // to decode
  output logic                 valid_o,
  output logic [31:0]          pc_if_o,
  output fetch_pkg::if_id_t    if_id_o,
  output logic                 busy_o,
  // instruction memory
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i
);
  import fetch_pkg::*;

  offset_state_e state_q, state_d;
  redirect_t     redirect_sel;

  logic        fetch_req;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic [31:0] fetch_rdata;
  logic [31:0] last_addr;
  // word address before last_addr, start of a crossword instruction
  logic [31:0] prev_addr_q;
  // upper halfword of the previous word
  logic [15:0] half_q;

  logic [1:0]  is_compressed;
  logic        unaligned;
  logic        crossword;
  logic        target_unaligned;
  logic        branch_taken;
  logic        jump_taken;
  logic        redirect_taken;
  logic        instr_taken;
  logic [31:0] instr_int;

  logic        id_valid_q;
  logic [31:0] id_instr_q;
  logic [31:0] id_pc_q;

  //////////////////////////////////////////////////////////////////////
  // redirect detection and next pc
  //////////////////////////////////////////////////////////////////////

  assign branch_taken = !stall_id_i && (redirect_i.jump_in_ex == JUMP_COND) &&
                        redirect_i.branch_taken;
  assign jump_taken   = !stall_id_i && ((redirect_i.jump_in_id == JUMP_JAL) ||
                                        (redirect_i.jump_in_id == JUMP_JALR));
  assign redirect_taken = branch_taken || jump_taken;

  // select is forced from what was taken, only exception and eret pass through
  always_comb begin
    redirect_sel = redirect_i;
    if (branch_taken) begin
      redirect_sel.pc_sel = PC_BRANCH;
    end else if (jump_taken) begin
      if ((redirect_i.pc_sel != PC_EXCEPTION) && (redirect_i.pc_sel != PC_ERET)) begin
        redirect_sel.pc_sel = PC_JUMP;
      end
    end else if (state_q == IDLE) begin
      redirect_sel.pc_sel = PC_BOOT;
    end else begin
      redirect_sel.pc_sel = PC_INCR;
    end
  end

  fetch_pc_select u_pc_select (
    .boot_addr_i        (boot_addr_i),
    .redirect_i         (redirect_sel),
    .last_addr_i        (last_addr),
    .next_addr_o        (fetch_addr),
    .target_unaligned_o (target_unaligned)
  );

  fetch_mem_port u_mem_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .last_addr_o    (last_addr),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  // low two bits not both set means 16-bit
  assign is_compressed[0] = (fetch_rdata[1:0] != 2'b11);
  assign is_compressed[1] = (fetch_rdata[17:16] != 2'b11);

  // IF instruction moves on, unless a redirect throws it away
  assign instr_taken = valid_o && req_i && !stall_if_i && !redirect_taken;

  //////////////////////////////////////////////////////////////////////
  // offset FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    fetch_req = 1'b0;
    valid_o   = 1'b0;
    unaligned = 1'b0;
    crossword = 1'b0;

    case (state_q)
      // nothing fetched yet, first request goes to the boot vector
      IDLE: begin
        if (req_i) begin
          fetch_req = 1'b1;
          state_d   = WAIT_JUMPED_ALIGNED;
        end
      end

      // instruction at word start, size unknown until data is back
      WAIT_ALIGNED, VALID_ALIGNED, WAIT_JUMPED_ALIGNED, VALID_JUMPED_ALIGNED: begin
        if (fetch_valid || (state_q == VALID_ALIGNED) || (state_q == VALID_JUMPED_ALIGNED)) begin
          valid_o = 1'b1;
          if ((state_q == WAIT_ALIGNED) || (state_q == VALID_ALIGNED)) begin
            state_d = VALID_ALIGNED;
          end else begin
            state_d = VALID_JUMPED_ALIGNED;
          end
          if (req_i && !stall_if_i) begin
            if (!is_compressed[0]) begin
              // 32-bit, next one starts the following word
              fetch_req = 1'b1;
              state_d   = WAIT_ALIGNED;
            end else if (is_compressed[1]) begin
              // upper half is another 16-bit one, already here
              state_d = UNALIGNED_16;
            end else begin
              // upper half starts a crossword 32-bit, go get its top
              fetch_req = 1'b1;
              state_d   = WAIT_UNALIGNED_32;
            end
          end
        end
      end

      // 16-bit in the upper half of the current word, no memory access
      UNALIGNED_16: begin
        unaligned = 1'b1;
        valid_o   = 1'b1;
        if (req_i && !stall_if_i) begin
          fetch_req = 1'b1;
          state_d   = WAIT_ALIGNED;
        end
      end

      // crossword 32-bit, low half buffered, top half in the new word
      WAIT_UNALIGNED_32, VALID_UNALIGNED_32: begin
        unaligned = 1'b1;
        crossword = 1'b1;
        if (fetch_valid || (state_q == VALID_UNALIGNED_32)) begin
          valid_o = 1'b1;
          state_d = VALID_UNALIGNED_32;
          if (req_i && !stall_if_i) begin
            if (is_compressed[1]) begin
              state_d = UNALIGNED_16;
            end else begin
              fetch_req = 1'b1;
              state_d   = WAIT_UNALIGNED_32;
            end
          end
        end
      end

      // jumped to a halfword, lower half of the word is not ours
      WAIT_JUMPED_UNALIGNED, VALID_JUMPED_UNALIGNED: begin
        unaligned = 1'b1;
        if (fetch_valid || (state_q == VALID_JUMPED_UNALIGNED)) begin
          state_d = VALID_JUMPED_UNALIGNED;
          if (is_compressed[1]) begin
            valid_o = 1'b1;
            if (req_i && !stall_if_i) begin
              fetch_req = 1'b1;
              state_d   = WAIT_ALIGNED;
            end
          end else begin
            // 32-bit, fetch the top half regardless of stalls
            fetch_req = 1'b1;
            state_d   = WAIT_UNALIGNED_32;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // redirects override whatever the FSM planned
    if (redirect_taken) begin
      fetch_req = 1'b1;
      state_d   = target_unaligned ? WAIT_JUMPED_UNALIGNED : WAIT_JUMPED_ALIGNED;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // word history, shifts on every accepted fetch
  always_ff @(posedge clk) begin
    if (fetch_req) begin
      half_q      <= fetch_rdata[31:16];
      prev_addr_q <= last_addr;
    end
  end

  // busy until an instruction is ready, or while the bus is requesting
  assign busy_o = !((state_q == IDLE) || (state_q == VALID_ALIGNED) ||
                    (state_q == VALID_JUMPED_ALIGNED) || (state_q == VALID_JUMPED_UNALIGNED) ||
                    (state_q == VALID_UNALIGNED_32) || (state_q == UNALIGNED_16)) ||
                  instr_req_o;

  //////////////////////////////////////////////////////////////////////
  // realignment and IF/ID register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    instr_int = fetch_rdata;
    pc_if_o   = {last_addr[31:2], 2'b00};
    if (unaligned) begin
      if (crossword) begin
        instr_int = {fetch_rdata[15:0], half_q};
        pc_if_o   = {prev_addr_q[31:2], 2'b10};
      end else begin
        // only the low 16 bits matter for a compressed instruction
        instr_int = {fetch_rdata[15:0], fetch_rdata[31:16]};
        pc_if_o   = {last_addr[31:2], 2'b10};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (!stall_id_i) begin
      id_valid_q <= instr_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_id_i) begin
      id_instr_q <= instr_int;
      id_pc_q    <= pc_if_o;
    end
  end

  assign if_id_o = '{id_valid: id_valid_q, instr: id_instr_q, pc: id_pc_q};

endmodule

//--- fetch_pc_select.sv
// next fetch address, purely combinational
// every output address is word aligned, bit 1 of the real target goes out separately
// last_addr_i is expected to be word aligned already
`timescale 1ns/1ps

module fetch_pc_select (
  input  logic [31:0]          boot_addr_i,
  input  fetch_pkg::redirect_t redirect_i,
  input  logic [31:0]          last_addr_i,
  output logic [31:0]          next_addr_o,
  output logic                 target_unaligned_o
);
  import fetch_pkg::*;

  logic [4:0]  exc_off;
  logic [31:0] exc_pc;
  logic [31:0] boot_pc;

  // exception vector offset from the cause
  always_comb begin
    case (redirect_i.exc_cause)
      EXC_ILLINSN: exc_off = EXC_OFF_ILLINSN;
      EXC_IRQ:     exc_off = EXC_OFF_IRQ;
      EXC_IRQ_NM:  exc_off = EXC_OFF_IRQ_NM;
      default:     exc_off = EXC_OFF_RST;
    endcase
  end

  // vector block is picked by the upper bits of the boot address
  assign exc_pc  = {boot_addr_i[31:5], exc_off};
  assign boot_pc = {boot_addr_i[31:5], EXC_OFF_RST};

  //////////////////////////////////////////////////////////////////////
  // address mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (redirect_i.pc_sel)
      PC_BOOT:      next_addr_o = boot_pc;
      PC_INCR:      next_addr_o = last_addr_i + 32'd4;
      // jump targets may point at a halfword, fetch the word holding it
      PC_JUMP:      next_addr_o = {redirect_i.jump_target_id[31:2], 2'b00};
      PC_BRANCH:    next_addr_o = {redirect_i.jump_target_ex[31:2], 2'b00};
      PC_EXCEPTION: next_addr_o = exc_pc;
      PC_ERET:      next_addr_o = {redirect_i.epc[31:2], 2'b00};
      // unused encodings restart from boot
      default:      next_addr_o = boot_pc;
    endcase
  end

  // halfword target, stage enters the unaligned jump states
  always_comb begin
    case (redirect_i.pc_sel)
      PC_JUMP:   target_unaligned_o = redirect_i.jump_target_id[1];
      PC_BRANCH: target_unaligned_o = redirect_i.jump_target_ex[1];
      PC_ERET:   target_unaligned_o = redirect_i.epc[1];
      // boot, increment and vectors are always word aligned
      default:   target_unaligned_o = 1'b0;
    endcase
  end

endmodule

//--- fetch_mem_port.sv
// request/grant/read-valid port to instruction memory, one read outstanding at most
// addr and req stay stable until grant, so a strobe that arrives while the port is busy
// is queued and goes out after the old read drains, one cycle late
// responses of superseded reads are swallowed, never reported on fetch_valid_o
`timescale 1ns/1ps

module fetch_mem_port (
  input  logic        clk,
  input  logic        rst_n,
  // stage side
  input  logic        fetch_req_i,
  input  logic [31:0] fetch_addr_i,
  output logic        fetch_valid_o,
  output logic [31:0] fetch_rdata_o,
  output logic [31:0] last_addr_o,
  // memory side
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT_GNT,
    PORT_WAIT_RVALID
  } port_state_e;

  port_state_e state_q, state_d;
  // address driven while waiting for grant
  logic [31:0] addr_q, addr_d;
  // strobe that came in while busy
  logic [31:0] pend_addr_q, pend_addr_d;
  logic        pend_q, pend_d;
  // outstanding read still belongs to the newest strobe
  logic        live_q, live_d;
  logic [31:0] rdata_q;
  logic [31:0] last_addr_q;
  logic        read_done;
  logic        port_free;

  assign read_done     = (state_q == PORT_WAIT_RVALID) && instr_rvalid_i;
  // no read in flight after this cycle's edge unless a new one is issued
  assign port_free     = (state_q == PORT_IDLE) || read_done;
  assign fetch_valid_o = read_done && live_q;
  // hold the last good word so the stage can keep working on it
  assign fetch_rdata_o = fetch_valid_o ? instr_rdata_i : rdata_q;
  assign last_addr_o   = last_addr_q;

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    pend_addr_d = pend_addr_q;
    pend_d      = pend_q;
    live_d      = live_q;
    instr_req_o  = (state_q == PORT_WAIT_GNT);
    instr_addr_o = addr_q;

    if (port_free) begin
      if (fetch_req_i) begin
        // fresh strobe goes straight onto the bus, same cycle
        instr_req_o  = 1'b1;
        instr_addr_o = fetch_addr_i;
        addr_d       = fetch_addr_i;
        live_d       = 1'b1;
        pend_d       = 1'b0;
        state_d      = instr_gnt_i ? PORT_WAIT_RVALID : PORT_WAIT_GNT;
      end else if (pend_q) begin
        // queued strobe, request rises next cycle
        addr_d  = pend_addr_q;
        live_d  = 1'b1;
        pend_d  = 1'b0;
        state_d = PORT_WAIT_GNT;
      end else begin
        state_d = PORT_IDLE;
      end
    end else begin
      // busy, a new strobe kills the current read and waits its turn
      if (fetch_req_i) begin
        live_d      = 1'b0;
        pend_d      = 1'b1;
        pend_addr_d = fetch_addr_i;
      end
      if ((state_q == PORT_WAIT_GNT) && instr_gnt_i) begin
        state_d = PORT_WAIT_RVALID;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= PORT_IDLE;
      pend_q      <= 1'b0;
      live_q      <= 1'b0;
      last_addr_q <= 32'h0;
    end else begin
      state_q <= state_d;
      pend_q  <= pend_d;
      live_q  <= live_d;
      if (fetch_req_i) begin
        last_addr_q <= fetch_addr_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    addr_q      <= addr_d;
    pend_addr_q <= pend_addr_d;
    if (fetch_valid_o) begin
      rdata_q <= instr_rdata_i;
    end
  end

endmodule

//--- fetch_pkg.sv
// shared types for the instruction fetch stage
// instruction set is RV32 with the compressed extension, so widths are fixed at 32 bits
// exception vectors live in a 32-byte block selected by boot_addr[31:5]

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // next pc selection
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT,
    PC_INCR,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_ERET
  } pc_sel_e;

  // kind of control transfer sitting in ID or EX
  typedef enum logic [1:0] {
    JUMP_NONE,
    JUMP_JAL,
    JUMP_JALR,
    JUMP_COND
  } jump_kind_e;

  // picks the vector inside the exception block
  typedef enum logic [1:0] {
    EXC_RESET,
    EXC_ILLINSN,
    EXC_IRQ,
    EXC_IRQ_NM
  } exc_cause_e;

  // vector offsets inside the 32-byte block
  localparam logic [4:0] EXC_OFF_RST     = 5'h00;
  localparam logic [4:0] EXC_OFF_ILLINSN = 5'h08;
  localparam logic [4:0] EXC_OFF_IRQ     = 5'h10;
  localparam logic [4:0] EXC_OFF_IRQ_NM  = 5'h18;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////

  // everything from ID, EX and the controller that can move fetch
  typedef struct packed {
    pc_sel_e     pc_sel;
    jump_kind_e  jump_in_id;
    jump_kind_e  jump_in_ex;
    logic        branch_taken;
    logic [31:0] jump_target_id;
    logic [31:0] jump_target_ex;
    exc_cause_e  exc_cause;
    logic [31:0] epc;
  } redirect_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic        id_valid;
    logic [31:0] instr;
    logic [31:0] pc;
  } if_id_t;

  // offset FSM, tracks where the next instruction starts in the fetched word
  typedef enum logic [3:0] {
    IDLE,
    WAIT_ALIGNED,
    VALID_ALIGNED,
    UNALIGNED_16,
    WAIT_UNALIGNED_32,
    VALID_UNALIGNED_32,
    WAIT_JUMPED_ALIGNED,
    VALID_JUMPED_ALIGNED,
    WAIT_JUMPED_UNALIGNED,
    VALID_JUMPED_UNALIGNED
  } offset_state_e;

endpackage
